// ==== design/adc_consts.svh ====
`ifndef ADC_CONSTS_SVH
`define ADC_CONSTS_SVH

// serial frame shape
`define ADC_BITS         12
`define ADC_LEAD_ZEROS   4
`define ADC_FRAME_SCLKS  16
`define ADC_CAL_SCLKS    32

// sclk half period in clk cycles for 1 MHz from 24 MHz
`define ADC_DIV_RESET    12
`define ADC_DIV_W        8

// axi4-lite
`define AXI_ADDR_W       4
`define AXI_DATA_W       32

`endif

// ==== design/adc_pkg.sv ====
`include "adc_consts.svh"

package adc_pkg;

    typedef logic [`ADC_BITS-1:0] sample_t;

    typedef enum logic [2:0] {
        RX_OFF,
        RX_CAL,
        RX_QUIET,
        RX_WAIT,
        RX_RECV
    } rx_state_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axi_resp_t;

    // word offsets of the register map
    typedef enum logic [3:0] {
        REG_CTRL   = 4'h0,
        REG_DIV    = 4'h4,
        REG_STATUS = 4'h8,
        REG_DATA   = 4'hC
    } reg_addr_t;

endpackage

// ==== design/adc_ctrl_if.sv ====
`include "adc_consts.svh"

interface adc_ctrl_if
    import adc_pkg::*;
();
    // register block to receiver
    logic                  enable;
    logic                  start;
    logic                  continuous;
    logic [`ADC_DIV_W-1:0] half_div;

    // receiver to register block
    logic                  ready;
    logic                  busy;
    sample_t               sample;
    logic                  sample_valid;

    modport regs (
        output enable, start, continuous, half_div,
        input  ready, busy, sample, sample_valid
    );

    modport rx (
        input  enable, start, continuous, half_div,
        output ready, busy, sample, sample_valid
    );

endinterface

// ==== design/adc_sclk_gen.sv ====
`include "adc_consts.svh"

module adc_sclk_gen (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  run,
    input  logic [`ADC_DIV_W-1:0] half_div,
    output logic                  sclk,
    output logic                  rise,
    output logic                  fall
);

    logic [`ADC_DIV_W-1:0] cnt;
    logic                  tick;

    // end of a half period
    assign tick = run && (cnt <= 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt  <= `ADC_DIV_W'(`ADC_DIV_RESET);
            sclk <= 1'b1;
            rise <= 1'b0;
            fall <= 1'b0;
        end else begin
            // strobes line up with the new sclk level
            rise <= tick && !sclk;
            fall <= tick && sclk;
            if (!run) begin
                cnt  <= half_div;
                sclk <= 1'b1;
            end else if (tick) begin
                cnt  <= half_div;
                sclk <= ~sclk;
            end else begin
                cnt <= cnt - 1'b1;
            end
        end
    end

endmodule

// ==== design/adc_serial_rx.sv ====
`include "adc_consts.svh"

module adc_serial_rx
    import adc_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    sdo,
    adc_ctrl_if.rx  ctrl,
    output logic    cs,
    output logic    sclk
);

    rx_state_t           state;
    logic [5:0]          sclk_cnt;
    logic [`ADC_DIV_W:0] quiet_cnt;
    sample_t             shift;
    logic                pending;
    logic                rise;

    // sclk only runs while a frame holds cs low
    adc_sclk_gen u_sclk_gen (
        .clk      (clk),
        .reset    (reset),
        .run      (!cs),
        .half_div (ctrl.half_div),
        .sclk     (sclk),
        .rise     (rise),
        .fall     ()
    );

    assign ctrl.busy = ~cs;

    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= RX_OFF;
            cs                <= 1'b1;
            ctrl.ready        <= 1'b0;
            ctrl.sample_valid <= 1'b0;
            pending           <= 1'b0;
            sclk_cnt          <= '0;
            quiet_cnt         <= '0;
        end else begin
            ctrl.sample_valid <= 1'b0;
            // hold a start that lands outside the wait state
            if (ctrl.start) begin
                pending <= 1'b1;
            end
            if (!ctrl.enable) begin
                state      <= RX_OFF;
                cs         <= 1'b1;
                ctrl.ready <= 1'b0;
                pending    <= 1'b0;
            end else begin
                case (state)
                    RX_OFF: begin
                        state    <= RX_CAL;
                        cs       <= 1'b0;
                        sclk_cnt <= '0;
                    end
                    RX_CAL: begin
                        if (rise) begin
                            if (sclk_cnt == 6'(`ADC_CAL_SCLKS - 1)) begin
                                state      <= RX_QUIET;
                                cs         <= 1'b1;
                                ctrl.ready <= 1'b1;
                                quiet_cnt  <= {ctrl.half_div, 1'b0};
                            end else begin
                                sclk_cnt <= sclk_cnt + 1'b1;
                            end
                        end
                    end
                    RX_QUIET: begin
                        // one full sclk period with cs high
                        if (quiet_cnt <= 1) begin
                            state <= RX_WAIT;
                        end else begin
                            quiet_cnt <= quiet_cnt - 1'b1;
                        end
                    end
                    RX_WAIT: begin
                        if (pending || ctrl.start || ctrl.continuous) begin
                            state    <= RX_RECV;
                            cs       <= 1'b0;
                            sclk_cnt <= '0;
                            pending  <= 1'b0;
                        end
                    end
                    RX_RECV: begin
                        if (rise) begin
                            if (sclk_cnt == 6'(`ADC_FRAME_SCLKS - 1)) begin
                                state             <= RX_QUIET;
                                cs                <= 1'b1;
                                quiet_cnt         <= {ctrl.half_div, 1'b0};
                                ctrl.sample_valid <= 1'b1;
                            end else begin
                                sclk_cnt <= sclk_cnt + 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= RX_OFF;
                        cs    <= 1'b1;
                    end
                endcase
            end
        end
    end

    // bit k of the frame taken at rise k with msb first after the zeros
    always_ff @(posedge clk) begin
        if (state == RX_RECV && rise) begin
            if (sclk_cnt >= 6'(`ADC_LEAD_ZEROS)) begin
                shift <= {shift[`ADC_BITS-2:0], sdo};
            end
            if (sclk_cnt == 6'(`ADC_FRAME_SCLKS - 1)) begin
                ctrl.sample <= {shift[`ADC_BITS-2:0], sdo};
            end
        end
    end

endmodule

// ==== design/adc_regs.sv ====
`include "adc_consts.svh"

module adc_regs
    import adc_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic [`AXI_ADDR_W-1:0]  awaddr,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`AXI_DATA_W-1:0]  wdata,
    input  logic [`AXI_DATA_W/8-1:0] wstrb,
    input  logic                    wvalid,
    output logic                    wready,
    output axi_resp_t               bresp,
    output logic                    bvalid,
    input  logic                    bready,
    input  logic [`AXI_ADDR_W-1:0]  araddr,
    input  logic                    arvalid,
    output logic                    arready,
    output logic [`AXI_DATA_W-1:0]  rdata,
    output axi_resp_t               rresp,
    output logic                    rvalid,
    input  logic                    rready,
    adc_ctrl_if.regs                ctrl
);

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   data_rd;
    logic                   wr_ok;
    logic                   rd_ok;
    logic [`AXI_DATA_W-1:0] rd_mux;
    logic                   new_data;
    logic                   overrun;
    sample_t                data;
    logic [15:0]            sample_cnt;

    assign wr_fire = awready && wready;
    assign rd_fire = arvalid && arready;
    assign data_rd = rd_fire && (araddr == REG_DATA);

    // every word slot of the 4-bit space is mapped
    assign wr_ok = (awaddr[1:0] == 2'b00);
    assign rd_ok = (araddr[1:0] == 2'b00);

    always_comb begin
        rd_mux = '0;
        case (araddr)
            REG_CTRL: begin
                rd_mux[0] = ctrl.enable;
                rd_mux[2] = ctrl.continuous;
            end
            REG_DIV: begin
                rd_mux[`ADC_DIV_W-1:0] = ctrl.half_div;
            end
            REG_STATUS: begin
                rd_mux[3:0] = {overrun, new_data, ctrl.busy, ctrl.ready};
            end
            REG_DATA: begin
                rd_mux[`ADC_BITS-1:0] = data;
                rd_mux[31:16]         = sample_cnt;
            end
            default: begin
                rd_mux = '0;
            end
        endcase
    end

    // handshakes
    always_ff @(posedge clk) begin
        if (reset) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
            end
            arready <= arvalid && !arready && !rvalid;
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end
        end
    end

    // held until the master takes them
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_mux;
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ctrl.enable     <= 1'b0;
            ctrl.start      <= 1'b0;
            ctrl.continuous <= 1'b0;
            ctrl.half_div   <= `ADC_DIV_W'(`ADC_DIV_RESET);
            new_data        <= 1'b0;
            overrun         <= 1'b0;
            data            <= '0;
            sample_cnt      <= '0;
        end else begin
            ctrl.start <= 1'b0;
            if (wr_fire && wstrb[0]) begin
                case (awaddr)
                    REG_CTRL: begin
                        ctrl.enable     <= wdata[0];
                        ctrl.start      <= wdata[1];
                        ctrl.continuous <= wdata[2];
                    end
                    REG_DIV: begin
                        // zero would stall the divider
                        if (wdata[`ADC_DIV_W-1:0] == '0) begin
                            ctrl.half_div <= {{(`ADC_DIV_W-1){1'b0}}, 1'b1};
                        end else begin
                            ctrl.half_div <= wdata[`ADC_DIV_W-1:0];
                        end
                    end
                    REG_STATUS: begin
                        if (wdata[3]) begin
                            overrun <= 1'b0;
                        end
                    end
                    default: begin
                    end
                endcase
            end
            if (data_rd) begin
                new_data <= 1'b0;
            end
            // a fresh sample wins over a clear in the same cycle
            if (ctrl.sample_valid) begin
                data       <= ctrl.sample;
                sample_cnt <= sample_cnt + 1'b1;
                new_data   <= 1'b1;
                if (new_data && !data_rd) begin
                    overrun <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/adc_top.sv ====
`include "adc_consts.svh"

module adc_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`AXI_ADDR_W-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [`AXI_DATA_W-1:0]   wdata,
    input  logic [`AXI_DATA_W/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [`AXI_ADDR_W-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [`AXI_DATA_W-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     cs,
    output logic                     sclk,
    input  logic                     sdo
);

    adc_ctrl_if ctrl_bus ();

    adc_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .ctrl    (ctrl_bus.regs)
    );

    adc_serial_rx u_rx (
        .clk   (clk),
        .reset (reset),
        .sdo   (sdo),
        .ctrl  (ctrl_bus.rx),
        .cs    (cs),
        .sclk  (sclk)
    );

endmodule

// ==== tb/adc_device_model.sv ====
`include "adc_consts.svh"

module adc_device_model
    import adc_pkg::*;
(
    input  logic cs,
    input  logic sclk,
    output logic sdo
);

    timeunit 1ns;
    timeprecision 1ps;

    sample_t                      values[$];
    logic [`ADC_FRAME_SCLKS-1:0]  frame;
    int                           bit_idx;
    int                           frames;

    initial begin
        sdo     = 1'b0;
        frame   = '0;
        bit_idx = 0;
        frames  = 0;
    end

    task automatic load(input sample_t value);
        values.push_back(value);
    endtask

    // a new conversion result at every cs fall
    always @(negedge cs) begin
        if (values.size() > 0) begin
            frame = {{`ADC_LEAD_ZEROS{1'b0}}, values.pop_front()};
        end else begin
            frame = '0;
        end
        frames  = frames + 1;
        bit_idx = `ADC_FRAME_SCLKS;
        sdo     = frame[`ADC_FRAME_SCLKS-1];
    end

    // bit k goes out at fall k ahead of rise k
    always @(negedge sclk) begin
        if (!cs && bit_idx > 0) begin
            bit_idx = bit_idx - 1;
            sdo     = frame[bit_idx];
        end
    end

endmodule

// ==== tb/adc_sva.sv ====
`include "adc_consts.svh"

module adc_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   cs,
    input logic                   sclk,
    input logic [1:0]             bresp,
    input logic                   bvalid,
    input logic                   bready,
    input logic [`AXI_DATA_W-1:0] rdata,
    input logic [1:0]             rresp,
    input logic                   rvalid,
    input logic                   rready
);

    timeunit 1ns;
    timeprecision 1ps;

    pins_idle_after_reset: assert property (@(posedge clk) reset |=> (cs && sclk))
        else begin
            $error("cs or sclk not high after reset");
            adc_tb.errors++;
        end

    // no sclk edge while cs stays high so sdo is only taken with cs low
    sclk_quiet_with_cs_high: assert property (@(posedge clk) disable iff (reset)
        (cs && $past(cs)) |-> sclk)
        else begin
            $error("sclk active while cs is high");
            adc_tb.errors++;
        end

    bresp_held: assert property (@(posedge clk) disable iff (reset)
        (bvalid && !bready) |=> (bvalid && $stable(bresp)))
        else begin
            $error("write response changed before bready");
            adc_tb.errors++;
        end

    rdata_held: assert property (@(posedge clk) disable iff (reset)
        (rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp)))
        else begin
            $error("read response changed before rready");
            adc_tb.errors++;
        end

endmodule

// ==== tb/adc_tb.sv ====
`include "adc_consts.svh"

module adc_tb
    import adc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     FRAMES       = 14;
    localparam int     CONVERSIONS  = 6;
    localparam int     HS_LIMIT     = 50;
    localparam int     POLL_LIMIT   = 2000;
    localparam int     FRAME_LIMIT  = `ADC_CAL_SCLKS * 2 * 255;
    localparam longint WATCHDOG_NS  = longint'(FRAMES) * 32 * 255 * 100 * 4;

    logic                     clk;
    logic                     reset;
    logic [`AXI_ADDR_W-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [`AXI_DATA_W-1:0]   wdata;
    logic [`AXI_DATA_W/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [`AXI_ADDR_W-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [`AXI_DATA_W-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;
    logic                     cs;
    logic                     sclk;
    logic                     sdo;

    // reference model state
    sample_t gen_vals[FRAMES + 2];
    int      next_frame;
    int      model_count;
    sample_t model_data;
    int      errors;
    int      tests_passed;
    int      tests_failed;

    adc_top dut (.*);

    adc_device_model converter (
        .cs   (cs),
        .sclk (sclk),
        .sdo  (sdo)
    );

    bind adc_top adc_sva assertions (.*);

    always #50 clk = ~clk;

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("Mismatch at %0t ns: %s read %h, expected %h", $time, what, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output logic [1:0] resp);
        int n;
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        while (!awready && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        // hold valid across the accepting edge
        @(negedge clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        repeat ($urandom % 3) @(negedge clk);
        bready = 1'b1;
        while (!bvalid && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        resp = bresp;
        @(negedge clk);
        bready = 1'b0;
        if (n >= HS_LIMIT) begin
            report_failure("AXI write got no handshake or no response");
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        arvalid = 1'b0;
        repeat ($urandom % 3) @(negedge clk);
        rready = 1'b1;
        while (!rvalid && n < HS_LIMIT) begin
            @(negedge clk);
            n++;
        end
        data = rdata;
        resp = rresp;
        @(negedge clk);
        rready = 1'b0;
        if (n >= HS_LIMIT) begin
            report_failure("AXI read got no handshake or no response");
        end
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, 4'hF, resp);
        if (resp !== RESP_OKAY) begin
            report_mismatch("write response", resp, RESP_OKAY);
        end
    endtask

    task automatic expect_read(input logic [3:0] addr, input logic [31:0] exp,
                               input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        if (data !== exp) begin
            report_mismatch(what, data, exp);
        end
        if (resp !== RESP_OKAY) begin
            report_mismatch({what, " response"}, resp, RESP_OKAY);
        end
    endtask

    task automatic wait_status(input int bit_idx, input logic value, input string what);
        logic [31:0] data;
        logic [1:0]  resp;
        int          n;
        n = 0;
        data = '0;
        do begin
            axi_read(REG_STATUS, data, resp);
            n++;
        end while (data[bit_idx] !== value && n < POLL_LIMIT);
        if (data[bit_idx] !== value) begin
            report_failure({what, " never showed up in STATUS"});
        end
    endtask

    task automatic wait_frames(input int count);
        int n;
        n = 0;
        while (converter.frames < count && n < FRAME_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (converter.frames < count) begin
            report_failure("converter frame never started");
        end
    endtask

    function automatic logic [31:0] data_word();
        return {model_count[15:0], 4'h0, model_data};
    endfunction

    // one started conversion checked against the next device value
    task automatic convert_once();
        write_reg(REG_CTRL, 32'h3);
        wait_status(2, 1'b1, "new data");
        model_count++;
        model_data = gen_vals[next_frame];
        next_frame++;
        expect_read(REG_DATA, data_word(), "DATA");
        expect_read(REG_STATUS, 32'h1, "STATUS after DATA read");
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] value;
        logic [1:0]  resp;
        logic [3:0]  strb;
        logic [3:0]  addr;
        logic [7:0]  model_div;
        logic        cont;
        int          base;
        int          start_errors;
        int          i;

        clk = 1'b0;
        reset = 1'b1;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        next_frame = 0;
        model_count = 0;
        model_data = '0;
        cont = 1'b0;

        void'($urandom(32'h576b));
        for (i = 0; i < FRAMES + 2; i++) begin
            gen_vals[i] = sample_t'($urandom);
            converter.load(gen_vals[i]);
        end

        repeat (8) @(negedge clk);
        reset = 1'b0;

        start_errors = errors;
        if ({cs, sclk} !== 2'b11) begin
            report_mismatch("cs and sclk", {cs, sclk}, 2'b11);
        end
        expect_read(REG_CTRL, 32'h0, "CTRL");
        expect_read(REG_STATUS, 32'h0, "STATUS");
        expect_read(REG_DIV, 32'(`ADC_DIV_RESET), "DIV");
        finish_test("reset values", start_errors);

        start_errors = errors;
        model_div = `ADC_DIV_RESET;
        repeat (8) begin
            value = $urandom;
            strb = 4'($urandom);
            axi_write(REG_DIV, value, strb, resp);
            // the divider sits in byte lane 0
            if (strb[0]) begin
                model_div = (value[7:0] == 8'h0) ? 8'h1 : value[7:0];
            end
            if (resp !== RESP_OKAY) begin
                report_mismatch("DIV write response", resp, RESP_OKAY);
            end
            expect_read(REG_DIV, {24'h0, model_div}, "DIV");
        end
        write_reg(REG_DIV, 32'h0);
        expect_read(REG_DIV, 32'h1, "DIV after writing 0");
        repeat (8) begin
            value = $urandom & 32'hFFFF_FFFE;
            strb = 4'($urandom);
            axi_write(REG_CTRL, value, strb, resp);
            if (strb[0]) begin
                cont = value[2];
            end
            expect_read(REG_CTRL, {29'h0, cont, 2'b00}, "CTRL");
        end
        repeat (4) begin
            addr = {2'($urandom), 2'($urandom % 3 + 1)};
            axi_write(addr, $urandom, 4'hF, resp);
            if (resp !== RESP_SLVERR) begin
                report_mismatch("unmapped write response", resp, RESP_SLVERR);
            end
            axi_read(addr, data, resp);
            if (resp !== RESP_SLVERR) begin
                report_mismatch("unmapped read response", resp, RESP_SLVERR);
            end
            if (data !== 32'h0) begin
                report_mismatch("unmapped read data", data, 32'h0);
            end
        end
        write_reg(REG_CTRL, 32'h0);
        finish_test("register access", start_errors);

        start_errors = errors;
        model_div = 8'(1 + $urandom % 8);
        write_reg(REG_DIV, model_div);
        write_reg(REG_CTRL, 32'h1);
        // calibration frame takes a device value and drops it
        next_frame++;
        wait_status(0, 1'b1, "ready");
        convert_once();
        finish_test("calibration", start_errors);

        start_errors = errors;
        repeat (CONVERSIONS) begin
            model_div = 8'(1 + $urandom % 16);
            write_reg(REG_DIV, model_div);
            convert_once();
        end
        finish_test("single conversions", start_errors);

        start_errors = errors;
        model_div = 8'(2 + $urandom % 4);
        write_reg(REG_DIV, model_div);
        base = next_frame;
        write_reg(REG_CTRL, 32'h5);
        wait_frames(base + 3);
        // the running third frame still completes
        write_reg(REG_CTRL, 32'h1);
        wait_status(1, 1'b0, "end of frame");
        next_frame = base + 3;
        model_count += 3;
        model_data = gen_vals[base + 2];
        expect_read(REG_STATUS, 32'hD, "STATUS with unread samples");
        expect_read(REG_DATA, data_word(), "DATA after overrun");
        write_reg(REG_STATUS, 32'h8);
        expect_read(REG_STATUS, 32'h1, "STATUS after overrun clear");
        finish_test("continuous and overrun", start_errors);

        start_errors = errors;
        write_reg(REG_DIV, 32'h4);
        base = next_frame;
        write_reg(REG_CTRL, 32'h3);
        wait_frames(base + 1);
        repeat (40) @(negedge clk);
        write_reg(REG_CTRL, 32'h0);
        next_frame++;
        @(negedge clk);
        if (cs !== 1'b1) begin
            report_mismatch("cs after disable", cs, 1'b1);
        end
        expect_read(REG_STATUS, 32'h0, "STATUS after disable");
        expect_read(REG_DATA, data_word(), "DATA after aborted frame");
        write_reg(REG_CTRL, 32'h1);
        next_frame++;
        wait_status(0, 1'b1, "ready");
        convert_once();
        if (converter.frames != next_frame) begin
            report_mismatch("converter frame count", converter.frames, next_frame);
        end
        finish_test("disable in mid-frame", start_errors);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run did not finish within %0d ns, stopped by the watchdog", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/adc_pkg.sv
design/adc_ctrl_if.sv
design/adc_sclk_gen.sv
design/adc_serial_rx.sv
design/adc_regs.sv
design/adc_top.sv
tb/adc_device_model.sv
tb/adc_sva.sv
tb/adc_tb.sv
